// ==== weight_reorder_top.f ====
design/weight_reorder_pkg.sv
design/row_if.sv
design/blk_if.sv
design/ram_1w2r.sv
design/row_ingress.sv
design/n2r_buffer_w.sv
design/block_egress.sv
design/weight_reorder_top.sv
tb/tb_weight_reorder.sv

// ==== Makefile ====
# Verilator build and run for the weight-reorder testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_weight_reorder
FILELIST  := weight_reorder_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/weight_reorder_stim.txt ====
// Per frame: 8 input rows (column 0 in the top 16 bits), 8 expected blocks
// (slot 0 in the low 16 bits), one line of 8 last flags, one line of 8 ack delays
// Frame 1 rows
A000_A001_A002_A003
A010_A011_A012_A013
A020_A021_A022_A023
A030_A031_A032_A033
A040_A041_A042_A043
A050_A051_A052_A053
A060_A061_A062_A063
A070_A071_A072_A073
// Frame 1 expected blocks
A011_A001_A010_A000
A013_A003_A012_A002
A031_A021_A030_A020
A033_A023_A032_A022
A051_A041_A050_A040
A053_A043_A052_A042
A071_A061_A070_A060
A073_A063_A072_A062
0 0 0 0 0 0 0 1
0 1 3 0 2 5 1 4
// Frame 2 rows
5E00_5E10_5E20_5E30
5E01_5E11_5E21_5E31
5E02_5E12_5E22_5E32
5E03_5E13_5E23_5E33
5E04_5E14_5E24_5E34
5E05_5E15_5E25_5E35
5E06_5E16_5E26_5E36
5E07_5E17_5E27_5E37
// Frame 2 expected blocks
5E11_5E10_5E01_5E00
5E31_5E30_5E21_5E20
5E13_5E12_5E03_5E02
5E33_5E32_5E23_5E22
5E15_5E14_5E05_5E04
5E35_5E34_5E25_5E24
5E17_5E16_5E07_5E06
5E37_5E36_5E27_5E26
0 0 0 0 0 0 0 1
4 0 2 7 1 0 3 2

// ==== tb/tb_weight_reorder.sv ====
// **********************************************************
// Self-checking testbench for the weight-reorder subsystem
// Rows, expected blocks and ack delays come from the stim file
// **********************************************************

`timescale 1ns/1ps

module tb_weight_reorder
    import weight_reorder_pkg::*;
();

    localparam int ROWS        = 8;
    localparam int COLS        = 4;
    localparam int CHUNK_COLS  = 2;
    localparam int ROW_W       = ELEM_W * COLS;
    localparam int BLK_W       = ELEM_W * BLOCK_ROWS * CHUNK_COLS;
    localparam int BLOCKS      = (ROWS / BLOCK_ROWS) * (COLS / CHUNK_COLS);
    // Rows, blocks, last flags, ack delays
    localparam int FRAME_WORDS = ROWS + 3 * BLOCKS;
    localparam int WAIT_LIMIT  = 2000;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             in_req;
    logic [ROW_W-1:0] in_data;
    logic             in_ack;
    logic             out_req;
    logic [BLK_W-1:0] out_data;
    logic             out_last;
    logic             out_ack;
    logic             frame_done;

    logic [63:0]      stim [2*FRAME_WORDS];
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;
    int               failed = 0;
    int               done_cnt = 0;
    int               err_mark;

    // Previous-edge copies for the protocol monitor
    logic             req_q = 1'b0;
    logic             ack_q = 1'b0;
    logic             out_req_q = 1'b0;
    logic [BLK_W-1:0] data_q = '0;

    weight_reorder_top #(
        .ROWS       (ROWS),
        .COLS       (COLS),
        .CHUNK_COLS (CHUNK_COLS)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_ack    (out_ack),
        .frame_done (frame_done)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("PASS  %s", name);
        end else begin
            failed++;
            $display("FAIL  %s (%0d errors)", name, errors - err_before);
        end
    endtask

    // Four-phase send of every row of one frame
    task automatic send_frame(input int f);
        int cnt;
        int hold;
        for (int r = 0; r < ROWS; r++) begin
            in_data = stim[f*FRAME_WORDS + r][ROW_W-1:0];
            in_req  = 1'b1;
            cnt = 0;
            while (!in_ack) begin
                @(negedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) abort_run("in_ack never rose for an input row");
            end
            // Keep the request up a little past the ack
            hold = int'($urandom % 3);
            repeat (hold) @(negedge clk);
            in_req = 1'b0;
            cnt = 0;
            while (in_ack) begin
                @(negedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) abort_run("in_ack stayed high after in_req fell");
            end
        end
    endtask

    // Receive and compare every block of one frame
    task automatic receive_frame(input int f);
        int base;
        int delay;
        int cnt;
        base = f * FRAME_WORDS + ROWS;
        for (int b = 0; b < BLOCKS; b++) begin
            cnt = 0;
            while (!out_req) begin
                @(negedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) abort_run("out_req never rose for a block");
            end
            check_value("out_data", 64'(out_data), stim[base + b]);
            check_value("out_last", {63'd0, out_last}, stim[base + BLOCKS + b]);
            delay = int'(stim[base + 2*BLOCKS + b]) + int'($urandom % 4);
            repeat (delay) @(negedge clk);
            out_ack = 1'b1;
            cnt = 0;
            while (out_req) begin
                @(negedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) abort_run("out_req stayed high after out_ack");
            end
            out_ack = 1'b0;
        end
        checks++;
        assert (done_cnt == f + 1) else begin
            errors++;
            $display("frame_done did not pulse exactly once in frame %0d", f + 1);
        end
    endtask

    // Protocol monitor, sampled before the DUT updates on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_ack && !ack_q) begin
                checks++;
                assert (req_q) else begin
                    errors++;
                    $display("in_ack rose without a pending in_req");
                end
            end
            if (!in_ack && ack_q) begin
                checks++;
                assert (!req_q) else begin
                    errors++;
                    $display("in_ack fell while in_req was still high");
                end
            end
            if (out_req && out_req_q) begin
                check_value("out_data", 64'(out_data), 64'(data_q));
            end
            if (frame_done) begin
                done_cnt++;
                checks++;
                assert (out_last) else begin
                    errors++;
                    $display("frame_done pulsed before the last block was loaded");
                end
            end
        end
        req_q     <= in_req;
        ack_q     <= in_ack;
        out_req_q <= out_req;
        data_q    <= out_data;
    end

    initial begin
        rst_n   = 1'b0;
        in_req  = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        void'($urandom(32'h560b_667d));
        $readmemh("tb/weight_reorder_stim.txt", stim);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        err_mark = errors;
        check_value("in_ack", {63'd0, in_ack}, 64'd0);
        check_value("out_req", {63'd0, out_req}, 64'd0);
        check_value("out_last", {63'd0, out_last}, 64'd0);
        check_value("frame_done", {63'd0, frame_done}, 64'd0);
        report_test("reset values", err_mark);

        // Frame 2 rows queue up while frame 1 is being sliced
        fork
            begin
                send_frame(0);
                send_frame(1);
            end
            begin
                err_mark = errors;
                receive_frame(0);
                report_test("frame 1 block order, last flag and frame_done", err_mark);
                err_mark = errors;
                receive_frame(1);
                report_test("frame 2 after return to idle with random ack delays", err_mark);
            end
        join

        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== design/weight_reorder_top.sv ====
// **********************************************************
// Weight-reorder subsystem with four-phase ports on both sides
// Set ROWS, COLS and CHUNK_COLS here; stages take them from this level
// **********************************************************

`timescale 1ns/1ps

module weight_reorder_top
    import weight_reorder_pkg::*;
#(
    parameter int ROWS       = 8,
    parameter int COLS       = 4,
    parameter int CHUNK_COLS = 2
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_req,
    input  logic [COLS*ELEM_W-1:0]                  in_data,
    output logic                                    in_ack,
    output logic                                    out_req,
    output logic [ELEM_W*BLOCK_ROWS*CHUNK_COLS-1:0] out_data,
    output logic                                    out_last,
    input  logic                                    out_ack,
    output logic                                    frame_done
);

    row_if #(.COLS(COLS)) row_bus ();
    blk_if #(.CHUNK_COLS(CHUNK_COLS)) blk_bus ();

    row_ingress #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) i_ingress (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_data (in_data),
        .in_ack  (in_ack),
        .row     (row_bus.producer)
    );

    n2r_buffer_w #(
        .ROWS       (ROWS),
        .COLS       (COLS),
        .CHUNK_COLS (CHUNK_COLS)
    ) i_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .row        (row_bus.consumer),
        .blk        (blk_bus.producer),
        .frame_done (frame_done)
    );

    block_egress #(
        .ROWS       (ROWS),
        .COLS       (COLS),
        .CHUNK_COLS (CHUNK_COLS)
    ) i_egress (
        .clk      (clk),
        .rst_n    (rst_n),
        .blk      (blk_bus.consumer),
        .out_req  (out_req),
        .out_data (out_data),
        .out_last (out_last),
        .out_ack  (out_ack)
    );

endmodule

// ==== design/block_egress.sv ====
// **********************************************************
// One-entry output register with a four-phase sender
// The register frees up only after the sink drops its ack
// **********************************************************

`timescale 1ns/1ps

module block_egress
    import weight_reorder_pkg::*;
#(
    parameter int ROWS       = 8,
    parameter int COLS       = 4,
    parameter int CHUNK_COLS = 2
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    blk_if.consumer                                 blk,
    output logic                                    out_req,
    output logic [ELEM_W*BLOCK_ROWS*CHUNK_COLS-1:0] out_data,
    output logic                                    out_last,
    input  logic                                    out_ack
);

    localparam int BLOCKS = (ROWS / BLOCK_ROWS) * (COLS / CHUNK_COLS);
    localparam int CW     = (BLOCKS > 1) ? $clog2(BLOCKS) : 1;

    typedef enum logic [1:0] {
        EG_EMPTY   = 2'd0,
        EG_REQ     = 2'd1,
        EG_RELEASE = 2'd2
    } eg_state_t;

    eg_state_t     eg_state;
    logic [CW-1:0] blk_cnt;

    assign blk.taken = (eg_state == EG_EMPTY) && blk.valid;
    assign out_req   = (eg_state == EG_REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eg_state <= EG_EMPTY;
            out_last <= 1'b0;
            blk_cnt  <= '0;
        end else begin
            case (eg_state)
                EG_EMPTY: begin
                    if (blk.taken) begin
                        eg_state <= EG_REQ;
                        out_last <= blk.last;
                        blk_cnt  <= (blk_cnt == CW'(BLOCKS - 1)) ? '0 : blk_cnt + 1'b1;
                    end
                end
                EG_REQ: begin
                    if (out_ack) begin
                        eg_state <= EG_RELEASE;
                    end
                end
                EG_RELEASE: begin
                    // Wait for the sink to finish its half
                    if (!out_ack) begin
                        eg_state <= EG_EMPTY;
                        out_last <= 1'b0;
                    end
                end
                default: eg_state <= EG_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (blk.taken) begin
            out_data <= blk.data;
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req |=> $stable(out_data) && $stable(out_last)
    );

    // Buffer's last flag lines up with the block count of a frame
    a_last_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        blk.taken |-> (blk.last == (blk_cnt == CW'(BLOCKS - 1)))
    );

endmodule

// ==== design/n2r_buffer_w.sv ====
// **********************************************************
// Stores a frame of weight rows, then emits vertical blocks
// Blocks walk row pairs slowly and column groups quickly
// **********************************************************

`timescale 1ns/1ps

module n2r_buffer_w
    import weight_reorder_pkg::*;
#(
    parameter int ROWS       = 8,
    parameter int COLS       = 4,
    parameter int CHUNK_COLS = 2
) (
    input  logic    clk,
    input  logic    rst_n,
    row_if.consumer row,
    blk_if.producer blk,
    output logic    frame_done
);

    localparam int ROW_W  = ELEM_W * COLS;
    localparam int BLK_W  = ELEM_W * BLOCK_ROWS * CHUNK_COLS;
    localparam int PAIRS  = ROWS / BLOCK_ROWS;
    localparam int GROUPS = COLS / CHUNK_COLS;
    localparam int AW     = $clog2(ROWS);
    localparam int PW     = (PAIRS > 1) ? $clog2(PAIRS) : 1;
    localparam int GW     = (GROUPS > 1) ? $clog2(GROUPS) : 1;

    buf_state_t        state;
    buf_state_t        state_next;
    logic [AW-1:0]     wr_cnt;
    logic [PW-1:0]     pair_idx;
    logic [GW-1:0]     col_idx;
    logic              ram_we;
    logic [AW-1:0]     raddr0;
    logic [AW-1:0]     raddr1;
    logic [ROW_W-1:0]  rd_upper;
    logic [ROW_W-1:0]  rd_lower;
    logic [BLK_W-1:0]  blk_word;
    logic              last_blk;

    // Rows are written in the cycle they are taken
    assign row.taken = (state == FILL) && row.valid;
    assign ram_we    = row.taken;

    assign last_blk = (pair_idx == PW'(PAIRS - 1)) && (col_idx == GW'(GROUPS - 1));

    always_comb begin
        state_next = state;
        case (state)
            IDLE:  if (row.valid) state_next = FILL;
            FILL:  if (row.taken && row.last) state_next = SLICE;
            SLICE: state_next = DRAIN;
            DRAIN: if (blk.taken) state_next = last_blk ? IDLE : SLICE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            wr_cnt     <= '0;
            pair_idx   <= '0;
            col_idx    <= '0;
            frame_done <= 1'b0;
        end else begin
            state      <= state_next;
            frame_done <= (state == DRAIN) && blk.taken && last_blk;
            if (ram_we) begin
                wr_cnt <= row.last ? '0 : wr_cnt + 1'b1;
            end
            // Column group is the fast index
            if (state == DRAIN && blk.taken) begin
                if (col_idx == GW'(GROUPS - 1)) begin
                    col_idx  <= '0;
                    pair_idx <= last_blk ? '0 : pair_idx + 1'b1;
                end else begin
                    col_idx <= col_idx + 1'b1;
                end
            end
        end
    end

    // Upper and lower row of the current pair
    assign raddr0 = AW'(pair_idx * BLOCK_ROWS);
    assign raddr1 = raddr0 + AW'(1);

    ram_1w2r #(
        .DATA_W (ROW_W),
        .DEPTH  (ROWS)
    ) i_row_ram (
        .clk    (clk),
        .we     (ram_we),
        .waddr  (wr_cnt),
        .din    (row.data),
        .raddr0 (raddr0),
        .raddr1 (raddr1),
        .dout0  (rd_upper),
        .dout1  (rd_lower)
    );

    // Column 0 is the top slot of a row; block slot 0 is the bottom
    always_comb begin : pack_block
        elem_t upper;
        elem_t lower;
        int    col;
        blk_word = '0;
        for (int c = 0; c < CHUNK_COLS; c++) begin
            col   = int'(col_idx) * CHUNK_COLS + c;
            upper = rd_upper[ROW_W - 1 - col * ELEM_W -: ELEM_W];
            lower = rd_lower[ROW_W - 1 - col * ELEM_W -: ELEM_W];
            blk_word[(BLOCK_ROWS * c) * ELEM_W +: ELEM_W]     = upper;
            blk_word[(BLOCK_ROWS * c + 1) * ELEM_W +: ELEM_W] = lower;
        end
    end

    assign blk.valid = (state == DRAIN);
    assign blk.data  = blk_word;
    assign blk.last  = last_blk;

    // Writes only in FILL with the frame's last row landing in the top slot
    a_write_in_fill: assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_we |-> (state == FILL) && (row.last == (wr_cnt == AW'(ROWS - 1)))
    );

    a_blk_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        blk.valid && !blk.taken |=> blk.valid && $stable(blk.data) && $stable(blk.last)
    );

endmodule

// ==== design/row_ingress.sv ====
// **********************************************************
// Four-phase receiver for input rows
// Captures each row once and offers it to the buffer until taken
// **********************************************************

`timescale 1ns/1ps

module row_ingress
    import weight_reorder_pkg::*;
#(
    parameter int ROWS = 8,
    parameter int COLS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_req,
    input  logic [COLS*ELEM_W-1:0] in_data,
    output logic                   in_ack,
    row_if.producer                row
);

    localparam int RW = (ROWS > 1) ? $clog2(ROWS) : 1;

    logic [RW-1:0] row_cnt;
    logic          accept;

    // New row only once the old one is gone and ack has dropped
    assign accept = in_req && !in_ack && !row.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack    <= 1'b0;
            row.valid <= 1'b0;
            row.last  <= 1'b0;
            row_cnt   <= '0;
        end else begin
            if (accept) begin
                in_ack    <= 1'b1;
                row.valid <= 1'b1;
                row.last  <= (row_cnt == RW'(ROWS - 1));
                row_cnt   <= (row_cnt == RW'(ROWS - 1)) ? '0 : row_cnt + 1'b1;
            end else begin
                if (!in_req) begin
                    in_ack <= 1'b0;
                end
                if (row.taken) begin
                    row.valid <= 1'b0;
                end
            end
        end
    end

    // Row payload, held while valid
    always_ff @(posedge clk) begin
        if (accept) begin
            row.data <= in_data;
        end
    end

    // Ack only ever answers a request seen on the previous edge
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req)
    );

endmodule

// ==== design/ram_1w2r.sv ====
// **********************************************************
// Row memory with one write port and two registered read ports
// A row pair comes out one cycle after its addresses are issued
// **********************************************************

`timescale 1ns/1ps

module ram_1w2r #(
    parameter int DATA_W = 64,
    parameter int DEPTH  = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [DATA_W-1:0]        din,
    input  logic [$clog2(DEPTH)-1:0] raddr0,
    input  logic [$clog2(DEPTH)-1:0] raddr1,
    output logic [DATA_W-1:0]        dout0,
    output logic [DATA_W-1:0]        dout1
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Both read ports sample every cycle
    always_ff @(posedge clk) begin
        dout0 <= mem[raddr0];
        dout1 <= mem[raddr1];
    end

endmodule

// ==== design/blk_if.sv ====
// **********************************************************
// Reordered block transfer from the buffer to the egress stage
// Same hold-until-taken rule as the row transfer
// **********************************************************

`timescale 1ns/1ps

interface blk_if
    import weight_reorder_pkg::*;
#(
    parameter int CHUNK_COLS = 2
) ();

    // One block is BLOCK_ROWS x CHUNK_COLS elements
    logic                                   valid;
    logic [ELEM_W*BLOCK_ROWS*CHUNK_COLS-1:0] data;
    logic                                   last;
    logic                                   taken;

    modport producer (
        output valid,
        output data,
        output last,
        input  taken
    );

    modport consumer (
        input  valid,
        input  data,
        input  last,
        output taken
    );

endinterface

// ==== design/row_if.sv ====
// **********************************************************
// Row transfer from the ingress stage into the reorder buffer
// Producer holds valid and data until taken is seen
// **********************************************************

`timescale 1ns/1ps

interface row_if
    import weight_reorder_pkg::*;
#(
    parameter int COLS = 4
) ();

    logic                   valid;
    logic [COLS*ELEM_W-1:0] data;
    // Set on the row that completes a frame
    logic                   last;
    logic                   taken;

    modport producer (
        output valid,
        output data,
        output last,
        input  taken
    );

    modport consumer (
        input  valid,
        input  data,
        input  last,
        output taken
    );

endinterface

// ==== design/weight_reorder_pkg.sv ====
// **********************************************************
// Shared constants and types for the weight-reorder subsystem
// Imported by every design unit that needs element width or states
// **********************************************************

package weight_reorder_pkg;

    // Width of one weight element in bits
    localparam int ELEM_W = 16;

    // Rows per vertical block, tied to the two RAM read ports
    localparam int BLOCK_ROWS = 2;

    // One weight element
    typedef logic [ELEM_W-1:0] elem_t;

    // Buffer controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FILL  = 2'd1,
        SLICE = 2'd2,
        DRAIN = 2'd3
    } buf_state_t;

endpackage
